// File: all.f
common/be_ctl_pkg.sv
verilog/fe_cmd_buffer.sv
director/fe_cmd_adapter.sv
director/be_director.sv
verilog/be_ctl_top.sv
tests/tb_be_ctl_asserts.sv
tests/tb_be_ctl.sv

// File: Bender.yml
package:
  name: be_ctl

sources:
  - common/be_ctl_pkg.sv
  - verilog/fe_cmd_buffer.sv
  - director/fe_cmd_adapter.sv
  - director/be_director.sv
  - verilog/be_ctl_top.sv
  - target: test
    files:
      - tests/tb_be_ctl_asserts.sv
      - tests/tb_be_ctl.sv

// File: tests/tb_be_ctl.sv
module tb_be_ctl
   import be_ctl_pkg::*;
();

   localparam logic [VADDR_W-1:0] PC_S    = 39'h12_8000_0100;
   localparam logic [VADDR_W-1:0] PC_T    = 39'h12_8000_0400;
   localparam logic [VADDR_W-1:0] FILL_VA = 39'h7f_ffff_f000;
   localparam int                 NO_CMD  = -1;
   localparam int                 CHK_W   = $bits(fe_cmd_s);

   // Event strobes of one stimulus row
   localparam logic [10:0] EV_NONE   = 11'h000;
   localparam logic [10:0] EV_CFG_LO = 11'h001;
   localparam logic [10:0] EV_CFG_HI = 11'h002;
   localparam logic [10:0] EV_BOOT   = 11'h004;
   localparam logic [10:0] EV_EX1    = 11'h008;
   localparam logic [10:0] EV_BR     = 11'h010;
   localparam logic [10:0] EV_TRAP   = 11'h020;
   localparam logic [10:0] EV_RET    = 11'h040;
   localparam logic [10:0] EV_FENCEI = 11'h080;
   localparam logic [10:0] EV_TLBF   = 11'h100;
   localparam logic [10:0] EV_FILL   = 11'h200;
   localparam logic [10:0] EV_MISS   = 11'h400;

   typedef struct packed {
      logic [10:0]        ev;
      logic [VADDR_W-1:0] a;
      logic [VADDR_W-1:0] b;
      logic               rdy;
      logic               cmd;
      logic [2:0]         op;
      logic [VADDR_W-1:0] va;
      logic               sub;
      logic               rsn;
      logic               flush;
   } row_t;

   logic                  clk_i;
   logic                  reset_i;
   logic                  freeze_i;
   logic                  cfg_w_v_i;
   logic [CFG_ADDR_W-1:0] cfg_addr_i;
   logic [CFG_DATA_W-1:0] cfg_data_i;
   logic                  ex1_v_i;
   logic                  ex1_instr_v_i;
   logic [VADDR_W-1:0]    ex1_pc_i;
   logic                  int1_v_i;
   logic                  int1_btaken_i;
   logic                  int1_br_or_jmp_i;
   logic [VADDR_W-1:0]    int1_br_tgt_i;
   logic [BR_META_W-1:0]  br_meta_i;
   logic                  mem1_fencei_v_i;
   logic                  mem3_miss_v_i;
   logic [VADDR_W-1:0]    mem3_pc_i;
   logic                  trap_v_i;
   logic                  ret_v_i;
   logic                  tlb_fence_i;
   logic [VADDR_W-1:0]    tvec_i;
   logic [VADDR_W-1:0]    epc_i;
   logic                  itlb_fill_v_i;
   logic [VADDR_W-1:0]    itlb_fill_vaddr_i;
   logic [PTE_W-1:0]      itlb_fill_entry_i;
   logic                  fe_cmd_ready_i;
   logic [VADDR_W-1:0]    expected_npc_o;
   logic [VADDR_W-1:0]    pc_o;
   logic                  flush_o;
   fe_cmd_s               fe_cmd_o;
   logic                  fe_cmd_v_o;

   row_t                  rows[$];
   fe_cmd_s               exp_q[$];
   logic [VADDR_W-1:0]    npc_model;
   logic [VADDR_W-1:0]    pc_model;
   int                    checks;
   int                    errors;
   int                    cycles;

   be_ctl_top DUT (.*);

   initial
   begin
      clk_i = 1'b0;
      forever #10 clk_i = ~clk_i;
   end

   task automatic check_value(input string name, input logic [CHK_W-1:0] got,
                              input logic [CHK_W-1:0] exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("[ERROR] t=%0t %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic add_row(input logic [10:0] ev, input logic [VADDR_W-1:0] a,
                          input logic [VADDR_W-1:0] b, input logic rdy, input int op,
                          input logic [VADDR_W-1:0] va, input logic sub, input logic rsn,
                          input logic flush);
      row_t r;
      r = '{ev, a, b, rdy, (op >= 0), 3'(op), va, sub, rsn, flush};
      rows.push_back(r);
   endtask

   task automatic drive_row(input row_t r, input int idx);
      if (r.ev & EV_BOOT)
         freeze_i = 1'b0;
      cfg_w_v_i         = |(r.ev & (EV_CFG_LO | EV_CFG_HI));
      cfg_addr_i        = (r.ev & EV_CFG_HI) ? CFG_START_PC_HI : CFG_START_PC_LO;
      cfg_data_i        = r.a[CFG_DATA_W-1:0];
      ex1_v_i           = |(r.ev & EV_EX1);
      ex1_instr_v_i     = ex1_v_i;
      ex1_pc_i          = r.a;
      int1_v_i          = ex1_v_i;
      int1_btaken_i     = |(r.ev & EV_BR);
      int1_br_or_jmp_i  = int1_btaken_i;
      int1_br_tgt_i     = r.b;
      br_meta_i         = 10'h2a5 ^ BR_META_W'(idx);
      mem1_fencei_v_i   = |(r.ev & EV_FENCEI);
      mem3_miss_v_i     = |(r.ev & EV_MISS);
      mem3_pc_i         = r.b;
      trap_v_i          = |(r.ev & EV_TRAP);
      ret_v_i           = |(r.ev & EV_RET);
      tvec_i            = r.a;
      epc_i             = r.a;
      tlb_fence_i       = |(r.ev & EV_TLBF);
      itlb_fill_v_i     = |(r.ev & EV_FILL);
      itlb_fill_vaddr_i = r.a;
      itlb_fill_entry_i = r.b[PTE_W-1:0];
      fe_cmd_ready_i    = r.rdy;
   endtask

   function automatic fe_cmd_s expected_cmd(input row_t r, input logic [BR_META_W-1:0] meta);
      fe_cmd_s c;
      c        = '0;
      c.opcode = fe_cmd_opcode_e'(r.op);
      c.vaddr  = r.va;
      if (c.opcode == op_pc_redirect)
      begin
         c.operands.redirect.subop   = redirect_subop_e'(r.sub);
         c.operands.redirect.br_meta = meta;
         c.operands.redirect.reason  = mispredict_reason_e'(r.rsn);
      end
      else if (c.opcode == op_attaboy)
         c.operands.attaboy.br_meta = meta;
      else if (c.opcode == op_itlb_fill)
         c.operands.itlb_fill_pte = r.b[PTE_W-1:0];
      return c;
   endfunction

   // Later assignments win, so the lowest priority source comes first
   task automatic update_model(input row_t r);
      logic [VADDR_W-1:0] nxt;
      logic               wr;
      nxt = npc_model + 4;
      if (r.ev & EV_BR)
         nxt = r.b;
      if (r.ev & EV_MISS)
         nxt = r.b;
      if (r.ev & EV_TRAP)
         nxt = {r.a[VADDR_W-1:2], 2'b00};
      if (r.ev & EV_RET)
         nxt = r.a;
      if (r.ev & EV_CFG_LO)
         nxt = {npc_model[VADDR_W-1:32], r.a[31:0]};
      if (r.ev & EV_CFG_HI)
         nxt = {r.a[6:0], npc_model[31:0]};
      wr = |(r.ev & (EV_CFG_LO | EV_CFG_HI | EV_TRAP | EV_RET | EV_MISS))
         | (|(r.ev & EV_EX1) & (r.a === npc_model));
      if (wr)
      begin
         pc_model  = npc_model;
         npc_model = nxt;
      end
   endtask

   task automatic sample_outputs(input row_t r);
      check_value("flush_o", flush_o, r.flush);
      if (!$isunknown(npc_model))
         check_value("expected_npc_o", expected_npc_o, npc_model);
      if (!$isunknown(pc_model))
         check_value("pc_o", pc_o, pc_model);
      // FE sees a command exactly while one is owed
      check_value("fe_cmd_v_o", fe_cmd_v_o, exp_q.size() != 0);
      // Head of the buffer must match the oldest command not yet taken
      if (exp_q.size() != 0)
      begin
         check_value("fe_cmd_o.opcode", fe_cmd_o.opcode, exp_q[0].opcode);
         check_value("fe_cmd_o.vaddr", fe_cmd_o.vaddr, exp_q[0].vaddr);
         check_value("fe_cmd_o.operands", fe_cmd_o.operands, exp_q[0].operands);
         if (fe_cmd_ready_i)
            void'(exp_q.pop_front());
      end
      if (r.cmd)
         exp_q.push_back(expected_cmd(r, br_meta_i));
   endtask

   task automatic build_table();
      add_row(EV_CFG_LO, PC_S, '0, 1, NO_CMD, '0, 0, 0, 0);
      add_row(EV_CFG_HI, PC_S >> 32, '0, 1, NO_CMD, '0, 0, 0, 0);
      add_row(EV_BOOT, '0, '0, 1, NO_CMD, '0, 0, 0, 0);
      add_row(EV_NONE, '0, '0, 1, op_state_reset, PC_S, 0, 0, 1);
      // Straight line, a taken branch, then the attaboy
      add_row(EV_EX1, PC_S, '0, 1, NO_CMD, '0, 0, 0, 0);
      add_row(EV_EX1, PC_S + 4, '0, 1, NO_CMD, '0, 0, 0, 0);
      add_row(EV_EX1 | EV_BR, PC_S + 8, PC_T, 1, NO_CMD, '0, 0, 0, 0);
      add_row(EV_EX1, PC_T, '0, 1, op_attaboy, PC_T, 0, 0, 0);
      add_row(EV_EX1, PC_T + 'h100, '0, 1, op_pc_redirect, PC_T + 4, 1, 0, 0);
      add_row(EV_EX1 | EV_BR, PC_T + 'h200, PC_T + 'h300, 1, op_pc_redirect, PC_T + 4, 1, 1, 0);
      // Branch from the mispredict is still pending after trap and return
      add_row(EV_TRAP, 39'h2003, '0, 1, op_pc_redirect, 39'h2000, 0, 0, 1);
      add_row(EV_RET, PC_T + 4, '0, 1, op_pc_redirect, PC_T + 4, 0, 0, 0);
      add_row(EV_EX1, PC_T + 4, '0, 1, op_attaboy, PC_T + 4, 0, 0, 0);
      add_row(EV_FILL, FILL_VA, 39'habc_def1, 1, op_itlb_fill, FILL_VA, 0, 0, 1);
      add_row(EV_TLBF, '0, PC_T + 'h400, 1, op_itlb_fence, PC_T + 'h400, 0, 0, 1);
      add_row(EV_FENCEI, '0, '0, 1, op_icache_fence, PC_T + 8, 0, 0, 1);
      add_row(EV_MISS, '0, PC_T + 'h500, 1, NO_CMD, '0, 0, 0, 0);
      add_row(EV_TLBF | EV_FENCEI | EV_TRAP, 39'h3001, PC_T + 'h600, 1,
              op_itlb_fence, PC_T + 'h600, 0, 0, 1);
      // FE drains the fence before the stall
      add_row(EV_NONE, '0, '0, 1, NO_CMD, '0, 0, 0, 0);
      // FE stalls, two commands fill the buffer and the trap is lost
      add_row(EV_FENCEI, '0, '0, 0, op_icache_fence, 39'h3000, 0, 0, 1);
      add_row(EV_TLBF, '0, 39'h12_0000_0010, 0, op_itlb_fence, 39'h12_0000_0010, 0, 0, 1);
      add_row(EV_TRAP, 39'h5002, '0, 0, NO_CMD, '0, 0, 0, 1);
      add_row(EV_NONE, '0, '0, 0, NO_CMD, '0, 0, 0, 0);
      repeat (3)
         add_row(EV_NONE, '0, '0, 1, NO_CMD, '0, 0, 0, 0);
   endtask

   initial
   begin
      row_t quiet_row;
      quiet_row     = '0;
      quiet_row.rdy = 1'b1;
      reset_i       = 1'b1;
      freeze_i      = 1'b1;
      drive_row(quiet_row, 0);
      npc_model     = 'x;
      pc_model      = '0;
      build_table();
      repeat (16) @(posedge clk_i);
      #2;
      reset_i = 1'b0;
      foreach (rows[i])
      begin
         @(posedge clk_i);
         #2;
         drive_row(rows[i], i);
         #16;
         sample_outputs(rows[i]);
         update_model(rows[i]);
      end
      @(posedge clk_i);
      #2;
      if (exp_q.size() != 0 || fe_cmd_v_o !== 1'b0)
      begin
         errors++;
         $display("Commands left undelivered at the end: %0d expected, fe_cmd_v_o=%b",
                  exp_q.size(), fe_cmd_v_o);
      end
      // Failed assertions in the bound checker count as errors too
      errors += DUT.u_director.u_asserts.fail_count;
      $display("Summary: %0d checks, %0d errors", checks, errors);
      if (errors == 0)
         $display("All tests passed!");
      else
         $display("Test failures found");
      $finish;
   end

   // Reset, every row, and some slack
   initial
   begin
      forever
      begin
         @(posedge clk_i);
         cycles++;
         if (cycles >= 16 + rows.size() + 20)
         begin
            $display("Timeout after %0d cycles, the stimulus loop never finished", cycles);
            $display("Test failures found");
            $finish;
         end
      end
   end

endmodule

// File: tests/tb_be_ctl_asserts.sv
module be_director_asserts
   import be_ctl_pkg::*;
(
   input logic               clk_i,
   input logic               reset_i,
   input logic               cfg_w_v_i,
   input logic               ex1_instr_v_i,
   input logic [VADDR_W-1:0] ex1_pc_i,
   input logic               mem3_miss_v_i,
   input logic               trap_v_i,
   input logic               ret_v_i,
   input logic [VADDR_W-1:0] tvec_i,
   input logic [VADDR_W-1:0] expected_npc_o,
   input logic               cmd_v_o
);

   int fail_count = 0;

   // A wrong-path instruction must not move the expected PC
   mismatch_holds_npc: assert property (@(posedge clk_i) disable iff (reset_i)
      (ex1_instr_v_i && (ex1_pc_i != expected_npc_o)
       && !(cfg_w_v_i || mem3_miss_v_i || trap_v_i || ret_v_i))
      |=> $stable(expected_npc_o))
   else
   begin
      $error("expected_npc_o moved on a mismatching ex1 instruction");
      fail_count++;
   end

   no_valid_in_reset: assert property (@(posedge clk_i) reset_i |-> !cmd_v_o)
   else
   begin
      $error("cmd_v_o high during reset");
      fail_count++;
   end

   // A trap restarts fetch at the aligned vector
   trap_loads_tvec: assert property (@(posedge clk_i) disable iff (reset_i)
      (trap_v_i && !ret_v_i && !cfg_w_v_i)
      |=> (expected_npc_o == {$past(tvec_i[VADDR_W-1:2]), 2'b00}))
   else
   begin
      $error("expected_npc_o not loaded from tvec_i after a trap");
      fail_count++;
   end

endmodule

bind be_director be_director_asserts u_asserts (
   .clk_i          (clk_i),
   .reset_i        (reset_i),
   .cfg_w_v_i      (cfg_w_v_i),
   .ex1_instr_v_i  (ex1_instr_v_i),
   .ex1_pc_i       (ex1_pc_i),
   .mem3_miss_v_i  (mem3_miss_v_i),
   .trap_v_i       (trap_v_i),
   .ret_v_i        (ret_v_i),
   .tvec_i         (tvec_i),
   .expected_npc_o (expected_npc_o),
   .cmd_v_o        (cmd_v_o)
);

// File: verilog/be_ctl_top.sv
module be_ctl_top
   import be_ctl_pkg::*;
(
   input  logic                  clk_i,
   input  logic                  reset_i,
   input  logic                  freeze_i,

   input  logic                  cfg_w_v_i,
   input  logic [CFG_ADDR_W-1:0] cfg_addr_i,
   input  logic [CFG_DATA_W-1:0] cfg_data_i,

   input  logic                  ex1_v_i,
   input  logic                  ex1_instr_v_i,
   input  logic [VADDR_W-1:0]    ex1_pc_i,
   input  logic                  int1_v_i,
   input  logic                  int1_btaken_i,
   input  logic [VADDR_W-1:0]    int1_br_tgt_i,
   input  logic                  int1_br_or_jmp_i,
   input  logic [BR_META_W-1:0]  br_meta_i,
   input  logic                  mem1_fencei_v_i,
   input  logic                  mem3_miss_v_i,
   input  logic [VADDR_W-1:0]    mem3_pc_i,

   input  logic                  trap_v_i,
   input  logic                  ret_v_i,
   input  logic [VADDR_W-1:0]    tvec_i,
   input  logic [VADDR_W-1:0]    epc_i,
   input  logic                  tlb_fence_i,

   input  logic                  itlb_fill_v_i,
   input  logic [VADDR_W-1:0]    itlb_fill_vaddr_i,
   input  logic [PTE_W-1:0]      itlb_fill_entry_i,

   input  logic                  fe_cmd_ready_i,

   output logic [VADDR_W-1:0]    expected_npc_o,
   output logic [VADDR_W-1:0]    pc_o,
   output logic                  flush_o,
   output fe_cmd_s               fe_cmd_o,
   output logic                  fe_cmd_v_o
);

   fe_cmd_s cmd_data;
   logic    cmd_v;
   logic    cmd_ready;

   // Director ports share names with the top, except the command side
   be_director u_director (
      .*,
      .cmd_ready_i (cmd_ready),
      .cmd_o       (cmd_data),
      .cmd_v_o     (cmd_v)
   );

   fe_cmd_buffer u_cmd_buffer (
      .clk_i          (clk_i),
      .reset_i        (reset_i),
      .cmd_i          (cmd_data),
      .cmd_v_i        (cmd_v),
      .cmd_ready_o    (cmd_ready),
      .fe_cmd_o       (fe_cmd_o),
      .fe_cmd_v_o     (fe_cmd_v_o),
      .fe_cmd_ready_i (fe_cmd_ready_i)
   );

endmodule

// File: director/be_director.sv
module be_director
   import be_ctl_pkg::*;
(
   input  logic                  clk_i,
   input  logic                  reset_i,
   input  logic                  freeze_i,

   input  logic                  cfg_w_v_i,
   input  logic [CFG_ADDR_W-1:0] cfg_addr_i,
   input  logic [CFG_DATA_W-1:0] cfg_data_i,

   input  logic                  ex1_v_i,
   input  logic                  ex1_instr_v_i,
   input  logic [VADDR_W-1:0]    ex1_pc_i,
   input  logic                  int1_v_i,
   input  logic                  int1_btaken_i,
   input  logic [VADDR_W-1:0]    int1_br_tgt_i,
   input  logic                  int1_br_or_jmp_i,
   input  logic [BR_META_W-1:0]  br_meta_i,
   input  logic                  mem1_fencei_v_i,
   input  logic                  mem3_miss_v_i,
   input  logic [VADDR_W-1:0]    mem3_pc_i,

   input  logic                  trap_v_i,
   input  logic                  ret_v_i,
   input  logic [VADDR_W-1:0]    tvec_i,
   input  logic [VADDR_W-1:0]    epc_i,
   input  logic                  tlb_fence_i,

   input  logic                  itlb_fill_v_i,
   input  logic [VADDR_W-1:0]    itlb_fill_vaddr_i,
   input  logic [PTE_W-1:0]      itlb_fill_entry_i,

   input  logic                  cmd_ready_i,

   output logic [VADDR_W-1:0]    expected_npc_o,
   output logic [VADDR_W-1:0]    pc_o,
   output logic                  flush_o,
   output fe_cmd_s               cmd_o,
   output logic                  cmd_v_o
);

   logic [VADDR_W-1:0] npc_r;
   logic [VADDR_W-1:0] npc_n;
   logic [VADDR_W-1:0] pc_r;
   logic [VADDR_W-1:0] npc_plus4;
   logic [VADDR_W-1:0] cfg_pc;
   logic               cfg_pc_lo_w;
   logic               cfg_pc_hi_w;
   logic               npc_w_v;
   logic               npc_mismatch;
   logic               btaken;
   logic               attaboy_pending_r;

   assign cfg_pc_lo_w = cfg_w_v_i & (cfg_addr_i == CFG_START_PC_LO);
   assign cfg_pc_hi_w = cfg_w_v_i & (cfg_addr_i == CFG_START_PC_HI);

   // Merge the written half with the half already held
   assign cfg_pc = cfg_pc_hi_w
                 ? {cfg_data_i[VADDR_W-CFG_DATA_W-1:0], npc_r[CFG_DATA_W-1:0]}
                 : {npc_r[VADDR_W-1:CFG_DATA_W], cfg_data_i};

   assign npc_plus4 = npc_r + VADDR_W'(4);
   assign btaken    = int1_v_i & int1_btaken_i;

   // Next PC candidate, highest priority first
   always_comb
   begin
      if (cfg_pc_lo_w | cfg_pc_hi_w)
         npc_n = cfg_pc;
      else if (ret_v_i)
         npc_n = epc_i;
      else if (trap_v_i)
         npc_n = {tvec_i[VADDR_W-1:2], 2'b00};
      else if (mem3_miss_v_i)
         npc_n = mem3_pc_i;
      else if (btaken)
         npc_n = int1_br_tgt_i;
      else
         npc_n = npc_plus4;
   end

   assign npc_mismatch = (npc_r != ex1_pc_i);

   // A mismatching instruction leaves the expected PC where it was
   assign npc_w_v = cfg_pc_lo_w
                  | cfg_pc_hi_w
                  | (ex1_instr_v_i & ~npc_mismatch)
                  | mem3_miss_v_i
                  | trap_v_i
                  | ret_v_i;

   always_ff @(posedge clk_i)
   begin
      if (npc_w_v)
         npc_r <= npc_n;
   end

   // PC of the instruction now retiring, used by the CSR side
   always_ff @(posedge clk_i)
   begin
      if (reset_i)
         pc_r <= '0;
      else if (npc_w_v)
         pc_r <= npc_r;
   end

   // Was the last ex1 instruction a branch or jump
   always_ff @(posedge clk_i)
   begin
      if (reset_i)
         attaboy_pending_r <= 1'b0;
      else if (ex1_v_i)
         attaboy_pending_r <= int1_br_or_jmp_i;
   end

   assign expected_npc_o = npc_r;
   assign pc_o           = pc_r;

   fe_cmd_adapter u_adapter (
      .clk_i             (clk_i),
      .reset_i           (reset_i),
      .freeze_i          (freeze_i),
      .cmd_ready_i       (cmd_ready_i),
      .npc_i             (npc_r),
      .npc_next_i        (npc_n),
      .npc_mismatch_i    (npc_mismatch),
      .attaboy_pending_i (attaboy_pending_r),
      .ex1_v_i           (ex1_v_i),
      .ex1_pc_i          (ex1_pc_i),
      .int1_br_or_jmp_i  (int1_br_or_jmp_i),
      .br_meta_i         (br_meta_i),
      .mem1_fencei_v_i   (mem1_fencei_v_i),
      .mem3_pc_i         (mem3_pc_i),
      .trap_v_i          (trap_v_i),
      .ret_v_i           (ret_v_i),
      .tlb_fence_i       (tlb_fence_i),
      .itlb_fill_v_i     (itlb_fill_v_i),
      .itlb_fill_vaddr_i (itlb_fill_vaddr_i),
      .itlb_fill_entry_i (itlb_fill_entry_i),
      .cmd_o             (cmd_o),
      .cmd_v_o           (cmd_v_o),
      .flush_o           (flush_o)
   );

endmodule

// File: director/fe_cmd_adapter.sv
module fe_cmd_adapter
   import be_ctl_pkg::*;
(
   input  logic                 clk_i,
   input  logic                 reset_i,
   input  logic                 freeze_i,
   input  logic                 cmd_ready_i,

   input  logic [VADDR_W-1:0]   npc_i,
   input  logic [VADDR_W-1:0]   npc_next_i,
   input  logic                 npc_mismatch_i,
   input  logic                 attaboy_pending_i,

   input  logic                 ex1_v_i,
   input  logic [VADDR_W-1:0]   ex1_pc_i,
   input  logic                 int1_br_or_jmp_i,
   input  logic [BR_META_W-1:0] br_meta_i,
   input  logic                 mem1_fencei_v_i,
   input  logic [VADDR_W-1:0]   mem3_pc_i,

   input  logic                 trap_v_i,
   input  logic                 ret_v_i,
   input  logic                 tlb_fence_i,

   input  logic                 itlb_fill_v_i,
   input  logic [VADDR_W-1:0]   itlb_fill_vaddr_i,
   input  logic [PTE_W-1:0]     itlb_fill_entry_i,

   output fe_cmd_s              cmd_o,
   output logic                 cmd_v_o,
   output logic                 flush_o
);

   logic [BOOT_STATE_W-1:0] state_r;
   logic [BOOT_STATE_W-1:0] state_n;
   logic                    cmd_found;

   // Boot sequence, one state reset to the FE after freeze drops
   always_comb
   begin
      state_n = state_r;
      case (state_r)
         BOOT_RESET: if (~freeze_i) state_n = BOOT_START;
         BOOT_START: if (cmd_v_o) state_n = BOOT_RUN;
         BOOT_RUN:   state_n = BOOT_RUN;
         default:    state_n = BOOT_RESET;
      endcase
   end

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
         state_r <= BOOT_RESET;
      else
         state_r <= state_n;
   end

   // One command per cycle, highest priority first
   always_comb
   begin
      cmd_o     = '0;
      cmd_found = 1'b0;
      if (state_r == BOOT_START)
      begin
         cmd_o.opcode = op_state_reset;
         cmd_o.vaddr  = npc_i;
         cmd_found    = 1'b1;
      end
      else if (state_r == BOOT_RUN)
      begin
         cmd_found = 1'b1;
         if (itlb_fill_v_i)
         begin
            cmd_o.opcode                 = op_itlb_fill;
            cmd_o.vaddr                  = itlb_fill_vaddr_i;
            cmd_o.operands.itlb_fill_pte = itlb_fill_entry_i;
         end
         else if (tlb_fence_i)
         begin
            cmd_o.opcode = op_itlb_fence;
            cmd_o.vaddr  = mem3_pc_i;
         end
         else if (mem1_fencei_v_i)
         begin
            cmd_o.opcode = op_icache_fence;
            cmd_o.vaddr  = npc_i;
         end
         else if (trap_v_i | ret_v_i)
         begin
            // Trap and return share the trap sub-opcode
            cmd_o.opcode                    = op_pc_redirect;
            cmd_o.vaddr                     = npc_next_i;
            cmd_o.operands.redirect.subop   = subop_trap;
            cmd_o.operands.redirect.br_meta = br_meta_i;
            cmd_o.operands.redirect.reason  = not_a_branch;
         end
         else if (ex1_v_i & npc_mismatch_i)
         begin
            cmd_o.opcode                    = op_pc_redirect;
            cmd_o.vaddr                     = npc_i;
            cmd_o.operands.redirect.subop   = subop_branch_mispredict;
            cmd_o.operands.redirect.br_meta = br_meta_i;
            if (int1_br_or_jmp_i)
               cmd_o.operands.redirect.reason = incorrect_prediction;
            else
               cmd_o.operands.redirect.reason = not_a_branch;
         end
         else if (ex1_v_i & ~npc_mismatch_i & attaboy_pending_i)
         begin
            // Prediction held, confirm it to the FE
            cmd_o.opcode                   = op_attaboy;
            cmd_o.vaddr                    = ex1_pc_i;
            cmd_o.operands.attaboy.br_meta = br_meta_i;
         end
         else
            cmd_found = 1'b0;
      end
   end

   // Offered only when the buffer has room
   assign cmd_v_o = cmd_found & cmd_ready_i;

   // Mispredicts and attaboys leave the pipeline alone
   assign flush_o = (cmd_v_o
                    & (cmd_o.opcode != op_attaboy)
                    & (cmd_o.opcode != op_pc_redirect))
                  | trap_v_i;

endmodule

// File: verilog/fe_cmd_buffer.sv
module fe_cmd_buffer
   import be_ctl_pkg::*;
(
   input  logic    clk_i,
   input  logic    reset_i,

   input  fe_cmd_s cmd_i,
   input  logic    cmd_v_i,
   output logic    cmd_ready_o,

   output fe_cmd_s fe_cmd_o,
   output logic    fe_cmd_v_o,
   input  logic    fe_cmd_ready_i
);

   fe_cmd_s                 mem [FE_CMD_DEPTH];
   logic [FE_CMD_PTR_W-1:0] wr_ptr_r;
   logic [FE_CMD_PTR_W-1:0] rd_ptr_r;
   logic [FE_CMD_CNT_W-1:0] count_r;
   logic                    wr_en;
   logic                    rd_en;

   // Wrap at the last slot, depth need not be a power of two
   function automatic logic [FE_CMD_PTR_W-1:0] ptr_inc(input logic [FE_CMD_PTR_W-1:0] ptr);
      if (ptr == FE_CMD_PTR_W'(FE_CMD_DEPTH - 1))
         return '0;
      else
         return ptr + 1'b1;
   endfunction

   assign cmd_ready_o = (count_r != FE_CMD_CNT_W'(FE_CMD_DEPTH));
   assign fe_cmd_v_o  = (count_r != '0);

   assign wr_en = cmd_v_i & cmd_ready_o;
   assign rd_en = fe_cmd_v_o & fe_cmd_ready_i;

   // Head entry stays put until the FE takes it
   assign fe_cmd_o = mem[rd_ptr_r];

   always_ff @(posedge clk_i)
   begin
      if (wr_en)
         mem[wr_ptr_r] <= cmd_i;
   end

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         wr_ptr_r <= '0;
         rd_ptr_r <= '0;
         count_r  <= '0;
      end
      else
      begin
         if (wr_en)
            wr_ptr_r <= ptr_inc(wr_ptr_r);
         if (rd_en)
            rd_ptr_r <= ptr_inc(rd_ptr_r);
         if (wr_en & ~rd_en)
            count_r <= count_r + 1'b1;
         else if (rd_en & ~wr_en)
            count_r <= count_r - 1'b1;
      end
   end

endmodule

// File: common/be_ctl_pkg.sv
package be_ctl_pkg;

   // Address and config channel widths
   localparam int VADDR_W    = 39;
   localparam int CFG_ADDR_W = 16;
   localparam int CFG_DATA_W = 32;

   // Start PC is written as a low word and a high remainder
   localparam logic [CFG_ADDR_W-1:0] CFG_START_PC_LO = 16'h0010;
   localparam logic [CFG_ADDR_W-1:0] CFG_START_PC_HI = 16'h0011;

   localparam int BR_META_W = 10;
   localparam int PTE_W     = 28;

   // Command buffer sizing
   localparam int FE_CMD_DEPTH = 2;
   localparam int FE_CMD_PTR_W = (FE_CMD_DEPTH > 1) ? $clog2(FE_CMD_DEPTH) : 1;
   localparam int FE_CMD_CNT_W = $clog2(FE_CMD_DEPTH + 1);

   // Operand word layout
   // The iTLB entry is the widest view and sets the word size
   localparam int OPERAND_W      = PTE_W;
   localparam int REDIRECT_PAD_W = OPERAND_W - 2 - BR_META_W - 2;
   localparam int ATTABOY_PAD_W  = OPERAND_W - BR_META_W;

   // Boot FSM encoding
   localparam int                      BOOT_STATE_W = 2;
   localparam logic [BOOT_STATE_W-1:0] BOOT_RESET   = 2'd0;
   localparam logic [BOOT_STATE_W-1:0] BOOT_START   = 2'd1;
   localparam logic [BOOT_STATE_W-1:0] BOOT_RUN     = 2'd2;

   typedef enum logic [2:0] {
      op_state_reset,
      op_pc_redirect,
      op_icache_fence,
      op_attaboy,
      op_itlb_fill,
      op_itlb_fence
   } fe_cmd_opcode_e;

   typedef enum logic [1:0] {
      subop_trap,
      subop_branch_mispredict
   } redirect_subop_e;

   typedef enum logic [1:0] {
      not_a_branch,
      incorrect_prediction
   } mispredict_reason_e;

   // One operand word, read according to the opcode
   typedef union packed {
      struct packed {
         redirect_subop_e           subop;
         logic [BR_META_W-1:0]      br_meta;
         mispredict_reason_e        reason;
         logic [REDIRECT_PAD_W-1:0] pad;
      } redirect;
      struct packed {
         logic [BR_META_W-1:0]     br_meta;
         logic [ATTABOY_PAD_W-1:0] pad;
      } attaboy;
      logic [PTE_W-1:0] itlb_fill_pte;
   } fe_cmd_operands_u;

   typedef struct packed {
      fe_cmd_opcode_e     opcode;
      logic [VADDR_W-1:0] vaddr;
      fe_cmd_operands_u   operands;
   } fe_cmd_s;

endpackage
